//--- tlk_tx_data.f
+incdir+.
tlk_tx_pkg.sv
tlk_tx_fifo.sv
tlk_tx_framer.sv
tlk_tx_line_out.sv
tlk_tx_data.sv
tb_tlk_tx_data.sv

//--- Bender.yml
package:
  name: tlk_tx_data

sources:
  - files:
      - tlk_tx_pkg.sv
      - tlk_tx_fifo.sv
      - tlk_tx_framer.sv
      - tlk_tx_line_out.sv
      - tlk_tx_data.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tlk_tx_data.sv

//--- tb_tlk_tx_model.svh
`ifndef TB_TLK_TX_MODEL_SVH
`define TB_TLK_TX_MODEL_SVH

////////////////////
// random source and expected line words

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// one line word as {tkmsb, tklsb, txd}
function automatic logic [17:0] line_word(input logic tkmsb, input logic tklsb,
                                          input logic [15:0] w);
    return {tkmsb, tklsb, w};
endfunction

// cycles from start pulse to the last gap word, plus one
function automatic int burst_len(input int body, input int num);
    return 1 + SYNC_LEN + (num + 1) * (8 + body / 2 + GAP_LEN);
endfunction

// appends one whole burst to exp_q, data taken from beat_q
task automatic build_burst(input logic [15:0] body, input logic [15:0] tail,
                           input logic [15:0] num);
    int          hw_idx;
    logic        last;
    logic [15:0] len;
    logic [15:0] sum;
    logic [15:0] data;
    logic [63:0] beat;
    hw_idx = 0;
    repeat (SYNC_LEN) exp_q.push_back(line_word(1'b0, 1'b1, {D5_6, K28_5}));
    for (int f = 0; f <= int'(num); f++) begin
        last = (f == int'(num));
        len  = last ? tail : body;
        sum  = 16'(f) + len;
        exp_q.push_back(line_word(1'b1, 1'b1, {K28_2, K27_7}));
        exp_q.push_back(line_word(1'b0, 1'b0, HEAD_0));
        exp_q.push_back(line_word(1'b0, 1'b0, HEAD_1));
        exp_q.push_back(line_word(1'b0, 1'b0, {TX_IND, last ? FILE_END : 8'h00}));
        exp_q.push_back(line_word(1'b0, 1'b0, 16'(f)));
        exp_q.push_back(line_word(1'b0, 1'b0, len));
        for (int i = 0; i < int'(body) / 2; i++) begin
            // lower halfword of a beat goes out first
            beat = beat_q[hw_idx / 4];
            data = beat[(hw_idx % 4) * 16 +: 16];
            sum  = sum + data;
            exp_q.push_back(line_word(1'b0, 1'b0, data));
            hw_idx++;
        end
        exp_q.push_back(line_word(1'b0, 1'b0, sum));
        exp_q.push_back(line_word(1'b1, 1'b1, {K29_7, K30_7}));
        repeat (GAP_LEN) exp_q.push_back(line_word(1'b0, 1'b1, {D5_6, K28_5}));
    end
endtask

`endif

//--- tb_tlk_tx_data.sv
`timescale 1ns/10ps

module tb_tlk_tx_data import tlk_tx_pkg::*; ();

    logic                 clk;
    logic                 i_soft_reset;
    logic [3:0]           i_tx_mode;
    logic                 i_tx_start;
    logic [15:0]          i_tx_packet_body;
    logic [15:0]          i_tx_packet_tail;
    logic [15:0]          i_tx_body_num;
    logic                 i_dma_rd_valid;
    logic [DMA_WIDTH-1:0] i_dma_rd_data;
    logic                 o_dma_rd_ready;
    logic                 o_tx_interrupt;
    logic [9:0]           o_tx_status;
    logic                 o_2711_tkmsb;
    logic                 o_2711_tklsb;
    logic                 o_2711_enable;
    logic                 o_2711_loopen;
    logic                 o_2711_lckrefn;
    logic                 o_2711_testen;
    logic                 o_2711_prbsen;
    logic [15:0]          o_2711_txd;

    logic [17:0] exp_q[$];
    logic [63:0] beat_q[$];
    logic [17:0] exp_word;
    logic [31:0] lcg_state;
    logic        seen_word;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          words_checked;
    int          irq_count;
    int          irq_before;
    int          wait_cnt;
    int          cycle_count;
    int          timeout_limit;

    `include "tb_tlk_tx_model.svh"

    tlk_tx_data UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic expect_equal(input string sig, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got === want) else begin
            $display("CHECK FAILED %s expected %h got %h", sig, want, got);
            errors++;
        end
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    task automatic prepare_beats(input int n);
        logic [31:0] lo;
        beat_q.delete();
        repeat (n) begin
            lo        = lcg_step(lcg_state);
            lcg_state = lcg_step(lo);
            beat_q.push_back({lcg_state, lo});
        end
    endtask

    task automatic push_beats();
        int   sent;
        logic took;
        sent = 0;
        @(posedge clk);
        i_dma_rd_valid <= 1'b1;
        i_dma_rd_data  <= beat_q[0];
        while (sent < beat_q.size()) begin
            @(negedge clk);
            took = o_dma_rd_ready;
            @(posedge clk);
            if (took) begin
                sent++;
                if (sent < beat_q.size()) begin
                    i_dma_rd_data <= beat_q[sent];
                end else begin
                    i_dma_rd_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic start_burst(input logic [3:0] mode, input logic [15:0] body,
                               input logic [15:0] tail, input logic [15:0] num);
        @(posedge clk);
        i_tx_mode        <= mode;
        i_tx_packet_body <= body;
        i_tx_packet_tail <= tail;
        i_tx_body_num    <= num;
        i_tx_start       <= 1'b1;
        @(posedge clk);
        i_tx_start <= 1'b0;
    endtask

    task automatic run_burst(input logic [15:0] body, input logic [15:0] tail,
                             input logic [15:0] num, input int beats);
        prepare_beats(beats);
        build_burst(body, tail, num);
        seen_word  = 1'b0;
        irq_before = irq_count;
        start_burst(MODE_NORM, body, tail, num);
        push_beats();
        while (exp_q.size() > 0) begin
            @(posedge clk);
        end
        repeat (4) @(negedge clk);
        expect_equal("o_tx_interrupt pulses", irq_count - irq_before, 1);
    endtask

    ////////////////////
    // line monitor

    always @(negedge clk) begin
        if (o_tx_interrupt) begin
            irq_count++;
        end
        // idle zeros ahead of the first comma are skipped
        if (exp_q.size() > 0 && (seen_word || o_2711_txd != 16'd0 || o_2711_tklsb)) begin
            seen_word = 1'b1;
            exp_word  = exp_q.pop_front();
            words_checked++;
            expect_equal("o_2711_txd", o_2711_txd, exp_word[15:0]);
            expect_equal("o_2711_tkmsb", o_2711_tkmsb, exp_word[17]);
            expect_equal("o_2711_tklsb", o_2711_tklsb, exp_word[16]);
            // interrupt lines up with the final gap word on the line
            expect_equal("o_tx_interrupt", o_tx_interrupt, exp_q.size() == 0);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout after %0d cycles, a burst never completed", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////
    // test sequence

    initial begin
        i_soft_reset     = 1'b1;
        i_tx_mode        = MODE_NORM;
        i_tx_start       = 1'b0;
        i_tx_packet_body = 16'd0;
        i_tx_packet_tail = 16'd0;
        i_tx_body_num    = 16'd0;
        i_dma_rd_valid   = 1'b0;
        i_dma_rd_data    = '0;
        lcg_state        = 32'hba62;
        seen_word        = 1'b0;
        errors           = 0;
        test_errors      = 0;
        tests_run        = 0;
        tests_failed     = 0;
        words_checked    = 0;
        irq_count        = 0;
        cycle_count      = 0;
        timeout_limit    = 2 * (burst_len(16, 0) + burst_len(8, 2) + burst_len(64, 0)) + 600;

        repeat (2) @(posedge clk);
        i_soft_reset <= 1'b0;
        @(negedge clk);
        expect_equal("o_tx_interrupt", o_tx_interrupt, 0);
        expect_equal("o_2711_tkmsb", o_2711_tkmsb, 0);
        expect_equal("o_2711_tklsb", o_2711_tklsb, 0);
        expect_equal("o_2711_txd", o_2711_txd, 0);
        expect_equal("o_2711_enable", o_2711_enable, 0);
        expect_equal("o_2711_lckrefn", o_2711_lckrefn, 0);
        expect_equal("o_2711_loopen", o_2711_loopen, 0);
        expect_equal("o_2711_testen", o_2711_testen, 0);
        expect_equal("o_2711_prbsen", o_2711_prbsen, 0);
        @(negedge clk);
        expect_equal("o_2711_enable", o_2711_enable, 1);
        expect_equal("o_2711_lckrefn", o_2711_lckrefn, 1);
        close_test("reset values");

        // beats offered in k-code mode must never land in the fifo
        prepare_beats(1);
        @(posedge clk);
        i_dma_rd_valid <= 1'b1;
        i_dma_rd_data  <= beat_q[0];
        start_burst(MODE_KCODE, 16'd16, 16'd16, 16'd0);
        @(posedge clk);
        repeat (16) begin
            @(negedge clk);
            expect_equal("o_2711_txd", o_2711_txd, {K28_2, K27_7});
            expect_equal("o_2711_tkmsb", o_2711_tkmsb, 1);
            expect_equal("o_2711_tklsb", o_2711_tklsb, 1);
            expect_equal("fifo empty", o_tx_status[9], 1);
        end
        expect_equal("mode", o_tx_status[3:0], MODE_KCODE);
        @(posedge clk);
        i_dma_rd_valid <= 1'b0;
        i_soft_reset   <= 1'b1;
        repeat (2) @(posedge clk);
        i_soft_reset <= 1'b0;
        close_test("k-code mode");

        run_burst(16'd16, 16'd10, 16'd0, 2);
        close_test("single frame");

        run_burst(16'd8, 16'd6, 16'd2, 3);
        close_test("three-frame burst");

        // fill enable still set from the earlier bursts and no start given
        prepare_beats(FIFO_DEPTH);
        push_beats();
        @(negedge clk);
        expect_equal("o_dma_rd_ready", o_dma_rd_ready, 0);
        expect_equal("fifo full", o_tx_status[8], 1);
        expect_equal("framer state", o_tx_status[7:4], ST_IDLE);
        start_burst(MODE_NORM, 16'd64, 16'd64, 16'd0);
        wait_cnt = 0;
        while (!o_dma_rd_ready && wait_cnt < 64) begin
            @(negedge clk);
            wait_cnt++;
        end
        assert (o_dma_rd_ready) else begin
            $display("o_dma_rd_ready stayed low after the framer started reading");
            errors++;
        end
        close_test("dma back-pressure");

        expect_equal("framer state", o_tx_status[7:4], ST_DATA);
        irq_before = irq_count;
        @(posedge clk);
        i_soft_reset <= 1'b1;
        repeat (2) @(posedge clk);
        i_soft_reset <= 1'b0;
        @(negedge clk);
        expect_equal("framer state", o_tx_status[7:4], ST_IDLE);
        expect_equal("fifo empty", o_tx_status[9], 1);
        repeat (GAP_LEN + 32) @(negedge clk);
        expect_equal("o_tx_interrupt pulses", irq_count - irq_before, 0);
        close_test("soft reset mid-frame");

        $display("tests %0d, failed %0d, words compared %0d, errors %0d",
                 tests_run, tests_failed, words_checked, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tlk_tx_data.sv
`timescale 1ns/10ps

module tlk_tx_data import tlk_tx_pkg::*; (
    input  logic                 clk,
    input  logic                 i_soft_reset,
    input  logic [3:0]           i_tx_mode,
    input  logic                 i_tx_start,
    input  logic [15:0]          i_tx_packet_body,
    input  logic [15:0]          i_tx_packet_tail,
    input  logic [15:0]          i_tx_body_num,
    input  logic                 i_dma_rd_valid,
    input  logic [DMA_WIDTH-1:0] i_dma_rd_data,
    output logic                 o_dma_rd_ready,
    output logic                 o_tx_interrupt,
    output logic [9:0]           o_tx_status,
    output logic                 o_2711_tkmsb,
    output logic                 o_2711_tklsb,
    output logic                 o_2711_enable,
    output logic                 o_2711_loopen,
    output logic                 o_2711_lckrefn,
    output logic                 o_2711_testen,
    output logic                 o_2711_prbsen,
    output logic [15:0]          o_2711_txd
);

    logic        fill_enable;
    logic        fifo_empty;
    logic        fifo_full;
    logic        fifo_rd_en;
    logic [15:0] fifo_rdata;
    tx_word_u    tx_word;
    logic        tx_tkmsb;
    logic        tx_tklsb;
    logic [3:0]  tx_state;
    logic [3:0]  tx_mode;

    tlk_tx_fifo u_fifo (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_fill_enable  (fill_enable),
        .i_dma_rd_valid (i_dma_rd_valid),
        .i_dma_rd_data  (i_dma_rd_data),
        .i_rd_en        (fifo_rd_en),
        .o_dma_rd_ready (o_dma_rd_ready),
        .o_rdata        (fifo_rdata),
        .o_empty        (fifo_empty),
        .o_full         (fifo_full)
    );

    tlk_tx_framer u_framer (
        .clk              (clk),
        .i_soft_reset     (i_soft_reset),
        .i_run            (fill_enable),
        .i_tx_start       (i_tx_start),
        .i_fifo_empty     (fifo_empty),
        .i_fifo_rdata     (fifo_rdata),
        .i_tx_packet_body (i_tx_packet_body),
        .i_tx_packet_tail (i_tx_packet_tail),
        .i_tx_body_num    (i_tx_body_num),
        .o_rd_en          (fifo_rd_en),
        .o_word           (tx_word),
        .o_tkmsb          (tx_tkmsb),
        .o_tklsb          (tx_tklsb),
        .o_state          (tx_state),
        .o_tx_interrupt   (o_tx_interrupt)
    );

    tlk_tx_line_out u_line_out (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_tx_start     (i_tx_start),
        .i_tx_mode      (i_tx_mode),
        .i_word         (tx_word),
        .i_tkmsb        (tx_tkmsb),
        .i_tklsb        (tx_tklsb),
        .o_fill_enable  (fill_enable),
        .o_mode         (tx_mode),
        .o_2711_txd     (o_2711_txd),
        .o_2711_tkmsb   (o_2711_tkmsb),
        .o_2711_tklsb   (o_2711_tklsb),
        .o_2711_enable  (o_2711_enable),
        .o_2711_lckrefn (o_2711_lckrefn)
    );

    // status word for software
    assign o_tx_status = {fifo_empty, fifo_full, tx_state, tx_mode};

    // loopback and test pattern pins unused on this link
    assign o_2711_loopen = 1'b0;
    assign o_2711_testen = 1'b0;
    assign o_2711_prbsen = 1'b0;

endmodule

//--- tlk_tx_line_out.sv
`timescale 1ns/10ps

module tlk_tx_line_out import tlk_tx_pkg::*; (
    input  logic        clk,
    input  logic        i_soft_reset,
    input  logic        i_tx_start,
    input  logic [3:0]  i_tx_mode,
    input  tx_word_u    i_word,
    input  logic        i_tkmsb,
    input  logic        i_tklsb,
    output logic        o_fill_enable,
    output logic [3:0]  o_mode,
    output logic [15:0] o_2711_txd,
    output logic        o_2711_tkmsb,
    output logic        o_2711_tklsb,
    output logic        o_2711_enable,
    output logic        o_2711_lckrefn
);

    logic     link_on;
    logic     kcode_sel;

    // start-of-frame pair repeated in k-code mode
    assign kcode_sel = (o_mode == MODE_KCODE);

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_mode        <= MODE_NORM;
            o_fill_enable <= 1'b0;
            link_on       <= 1'b0;
        end else begin
            link_on <= 1'b1;
            if (i_tx_start) begin
                o_mode <= i_tx_mode;
            end
            if (i_tx_start && i_tx_mode == MODE_NORM) begin
                o_fill_enable <= 1'b1;
            end
        end
    end

    ////////////////////
    // transceiver output register

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_2711_txd   <= 16'd0;
            o_2711_tkmsb <= 1'b0;
            o_2711_tklsb <= 1'b0;
        end else begin
            o_2711_txd   <= kcode_sel ? {K28_2, K27_7} : i_word.word;
            o_2711_tkmsb <= kcode_sel | i_tkmsb;
            o_2711_tklsb <= kcode_sel | i_tklsb;
        end
    end

    assign o_2711_enable  = link_on;
    assign o_2711_lckrefn = link_on;

endmodule

//--- tlk_tx_framer.sv
`timescale 1ns/10ps

module tlk_tx_framer import tlk_tx_pkg::*; (
    input  logic        clk,
    input  logic        i_soft_reset,
    input  logic        i_run,
    input  logic        i_tx_start,
    input  logic        i_fifo_empty,
    input  logic [15:0] i_fifo_rdata,
    input  logic [15:0] i_tx_packet_body,
    input  logic [15:0] i_tx_packet_tail,
    input  logic [15:0] i_tx_body_num,
    output logic        o_rd_en,
    output tx_word_u    o_word,
    output logic        o_tkmsb,
    output logic        o_tklsb,
    output logic [3:0]  o_state,
    output logic        o_tx_interrupt
);

    logic [3:0]            state;
    logic                  cfg_flag;
    logic [SYNC_CNT_W-1:0] sync_cnt;
    logic                  head_cnt;
    logic [14:0]           data_cnt;
    logic [GAP_CNT_W-1:0]  gap_cnt;
    logic [15:0]           frame_cnt;
    logic                  last_frame;
    logic [15:0]           checksum;
    // file parameters held for the whole burst
    logic [15:0]           body_q;
    logic [15:0]           tail_q;
    logic [15:0]           body_num_q;
    logic                  sync_done;
    logic                  data_done;
    logic                  gap_done;

    assign sync_done = (sync_cnt == SYNC_CNT_W'(SYNC_LEN - 1));
    assign data_done = (data_cnt == body_q[15:1] - 15'd1);
    assign gap_done  = (gap_cnt == GAP_CNT_W'(GAP_LEN - 1));

    assign o_state = state;
    assign o_rd_en = (state == ST_DATA);

    ////////////////////
    // frame sequencer

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_run && cfg_flag && !i_fifo_empty) begin
                        state <= ST_BEGIN;
                    end
                end
                ST_BEGIN:     state <= ST_SYNC;
                ST_SYNC:      state <= sync_done ? ST_SOF : ST_SYNC;
                ST_SOF:       state <= ST_HEAD;
                ST_HEAD:      state <= head_cnt ? ST_FILE_SIGN : ST_HEAD;
                ST_FILE_SIGN: state <= ST_FRAME_NUM;
                ST_FRAME_NUM: state <= ST_VLD_LEN;
                ST_VLD_LEN:   state <= ST_DATA;
                ST_DATA:      state <= data_done ? ST_TAIL : ST_DATA;
                ST_TAIL:      state <= ST_EOF;
                ST_EOF:       state <= ST_GAP;
                ST_GAP: begin
                    if (gap_done) begin
                        state <= last_frame ? ST_IDLE : ST_SOF;
                    end
                end
                default:      state <= ST_IDLE;
            endcase
        end
    end

    // counters, frame number and burst flags
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            cfg_flag       <= 1'b0;
            sync_cnt       <= '0;
            head_cnt       <= 1'b0;
            data_cnt       <= '0;
            gap_cnt        <= '0;
            frame_cnt      <= '0;
            last_frame     <= 1'b0;
            o_tx_interrupt <= 1'b0;
        end else begin
            if (i_tx_start) begin
                cfg_flag <= 1'b1;
            end else if (state == ST_GAP) begin
                cfg_flag <= 1'b0;
            end
            sync_cnt <= (state == ST_SYNC) ? sync_cnt + 1'b1 : '0;
            head_cnt <= (state == ST_HEAD) ? ~head_cnt : 1'b0;
            data_cnt <= (state == ST_DATA) ? data_cnt + 1'b1 : '0;
            gap_cnt  <= (state == ST_GAP) ? gap_cnt + 1'b1 : '0;
            if (state == ST_SOF) begin
                last_frame <= (frame_cnt == body_num_q);
            end
            if (state == ST_EOF) begin
                frame_cnt <= last_frame ? 16'd0 : frame_cnt + 16'd1;
            end
            o_tx_interrupt <= (state == ST_GAP) && gap_done && last_frame;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_BEGIN) begin
            body_q     <= i_tx_packet_body;
            tail_q     <= i_tx_packet_tail;
            body_num_q <= i_tx_body_num;
        end
        // frame number, length and data words
        if (state == ST_SOF) begin
            checksum <= 16'd0;
        end else if (state inside {ST_FRAME_NUM, ST_VLD_LEN, ST_DATA}) begin
            checksum <= checksum + o_word.word;
        end
    end

    ////////////////////
    // word generation

    always_comb begin
        o_word.word = 16'd0;
        o_tkmsb     = 1'b0;
        o_tklsb     = 1'b0;
        case (state)
            ST_SYNC, ST_GAP: begin
                o_word.chars.hi = D5_6;
                o_word.chars.lo = K28_5;
                o_tklsb         = 1'b1;
            end
            ST_SOF: begin
                o_word.chars.hi = K28_2;
                o_word.chars.lo = K27_7;
                o_tkmsb         = 1'b1;
                o_tklsb         = 1'b1;
            end
            ST_HEAD:      o_word.word = head_cnt ? HEAD_1 : HEAD_0;
            ST_FILE_SIGN: begin
                o_word.chars.hi = TX_IND;
                o_word.chars.lo = last_frame ? FILE_END : 8'h00;
            end
            ST_FRAME_NUM: o_word.word = frame_cnt;
            // the tail length only goes out on the last frame
            ST_VLD_LEN:   o_word.word = last_frame ? tail_q : body_q;
            ST_DATA:      o_word.word = i_fifo_rdata;
            ST_TAIL:      o_word.word = checksum;
            ST_EOF: begin
                o_word.chars.hi = K29_7;
                o_word.chars.lo = K30_7;
                o_tkmsb         = 1'b1;
                o_tklsb         = 1'b1;
            end
            default:      o_word.word = 16'd0;
        endcase
    end

endmodule

//--- tlk_tx_fifo.sv
`timescale 1ns/10ps

module tlk_tx_fifo import tlk_tx_pkg::*; (
    input  logic                 clk,
    input  logic                 i_soft_reset,
    input  logic                 i_fill_enable,
    input  logic                 i_dma_rd_valid,
    input  logic [DMA_WIDTH-1:0] i_dma_rd_data,
    input  logic                 i_rd_en,
    output logic                 o_dma_rd_ready,
    output logic [15:0]          o_rdata,
    output logic                 o_empty,
    output logic                 o_full
);

    logic [DMA_WIDTH-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW:0]      wr_ptr;
    logic [FIFO_AW:0]      rd_ptr;
    logic [HALF_SEL_W-1:0] half_sel;
    logic [DMA_WIDTH-1:0]  head_beat;
    logic                  wr_en;
    logic                  beat_pop;

    // extra pointer bit tells full from empty
    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                     (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    assign o_dma_rd_ready = ~o_full;

    // beats offered while filling is off are lost
    assign wr_en = i_dma_rd_valid & o_dma_rd_ready & i_fill_enable;

    // last halfword of the beat frees the slot
    assign beat_pop = i_rd_en & (&half_sel);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= i_dma_rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            half_sel <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_rd_en) begin
                half_sel <= half_sel + 1'b1;
            end
            if (beat_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // fall-through read, lower halfword goes out first
    assign head_beat = mem[rd_ptr[FIFO_AW-1:0]];
    assign o_rdata   = head_beat[{half_sel, 4'b0000} +: 16];

endmodule

//--- tlk_tx_pkg.sv
package tlk_tx_pkg;

    ////////////////////
    // modes

    localparam logic [3:0] MODE_NORM  = 4'd0;
    localparam logic [3:0] MODE_KCODE = 4'd2;

    ////////////////////
    // 8b/10b code groups

    // comma pair
    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] D5_6  = 8'hC5;
    // start of frame
    localparam logic [7:0] K27_7 = 8'hFB;
    localparam logic [7:0] K28_2 = 8'h5C;
    // end of frame
    localparam logic [7:0] K30_7 = 8'hFE;
    localparam logic [7:0] K29_7 = 8'hFD;

    localparam logic [7:0] TX_IND   = 8'h81;
    localparam logic [7:0] FILE_END = 8'h01;

    localparam logic [15:0] HEAD_0 = 16'hEB90;
    localparam logic [15:0] HEAD_1 = 16'hE116;

    ////////////////////
    // frame sizes and widths

    localparam int SYNC_LEN   = 6;
    localparam int GAP_LEN    = 256;
    localparam int DMA_WIDTH  = 64;
    localparam int FIFO_DEPTH = 8;

    localparam int SYNC_CNT_W = $clog2(SYNC_LEN);
    localparam int GAP_CNT_W  = $clog2(GAP_LEN);
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    // halfword select inside one dma beat
    localparam int HALF_SEL_W = $clog2(DMA_WIDTH / 16);

    ////////////////////
    // framer states

    localparam logic [3:0] ST_IDLE      = 4'd0;
    localparam logic [3:0] ST_BEGIN     = 4'd1;
    localparam logic [3:0] ST_SYNC      = 4'd2;
    localparam logic [3:0] ST_SOF       = 4'd3;
    localparam logic [3:0] ST_HEAD      = 4'd4;
    localparam logic [3:0] ST_FILE_SIGN = 4'd5;
    localparam logic [3:0] ST_FRAME_NUM = 4'd6;
    localparam logic [3:0] ST_VLD_LEN   = 4'd7;
    localparam logic [3:0] ST_DATA      = 4'd8;
    localparam logic [3:0] ST_TAIL      = 4'd9;
    localparam logic [3:0] ST_EOF       = 4'd10;
    localparam logic [3:0] ST_GAP       = 4'd11;

    // transmit word, either one data word or two code groups
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } tx_chars_t;

    typedef union packed {
        logic [15:0] word;
        tx_chars_t   chars;
    } tx_word_u;

endpackage
